// ==== source/fifo_demo_pkg.sv ====
`default_nettype none

package fifo_demo_pkg;

    // frame geometry
    localparam int unsigned FRAME_LEN = 12;
    // counter width for 0..FRAME_LEN
    localparam int unsigned FRAME_CW = $clog2(FRAME_LEN + 1);

    // fifo sizing, holds one frame at a time
    localparam int unsigned FIFO_DEPTH = 16;
    localparam int unsigned FIFO_AW = 4;

    // key filter, cycles a new level must hold
    localparam int unsigned DEBOUNCE_CYCLES = 16;
    localparam int unsigned DEBOUNCE_W = $clog2(DEBOUNCE_CYCLES + 1);

    // display paging
    localparam int unsigned PAGE_COUNT = 3;
    localparam int unsigned BYTES_PER_PAGE = 4;

    // one fifo entry
    typedef logic [7:0] byte_t;

    // byte 0 sits in the top bits
    typedef logic [FRAME_LEN*8-1:0] frame_t;

    // page index and page leds
    typedef logic [1:0] page_t;
    typedef logic [3:0] lec_t;

    // data leds, one page wide
    typedef logic [BYTES_PER_PAGE*8-1:0] led_t;

endpackage

`default_nettype wire

// ==== source/fifo_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fifo_port_if
    import fifo_demo_pkg::*;
();

    // write side
    logic  wr_en;
    byte_t din;
    logic  full;

    // read side, dout valid the cycle after rd_en
    logic  rd_en;
    byte_t dout;
    logic  empty;

    modport writer (output wr_en, output din, input full);
    modport reader (output rd_en, input dout, input empty);
    modport mem (input wr_en, input din, output full, input rd_en, output dout, output empty);

endinterface

`default_nettype wire

// ==== source/key_debounce.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_debounce
    import fifo_demo_pkg::*;
(
    input  logic sysc,
    input  logic rst,
    input  logic key_n,
    output logic press,
    output logic release_evt
);

    // two-flop synchronizer stages
    logic key_m;
    logic key_s;
    // accepted level, 1 means released
    logic level;
    // cycles the synced level has differed from the accepted one
    logic [DEBOUNCE_W-1:0] cnt;

    // idle key reads high
    always_ff @(posedge sysc or posedge rst) begin
        if (rst) begin
            key_m <= 1'b1;
            key_s <= 1'b1;
        end else begin
            key_m <= key_n;
            key_s <= key_m;
        end
    end

    always_ff @(posedge sysc or posedge rst) begin
        if (rst) begin
            level       <= 1'b1;
            cnt         <= '0;
            press       <= 1'b0;
            release_evt <= 1'b0;
        end else begin
            press       <= 1'b0;
            release_evt <= 1'b0;
            if (key_s == level) begin
                // glitch gone, start over
                cnt <= '0;
            end else if (cnt == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1)) begin
                // stable long enough, take it
                cnt         <= '0;
                level       <= key_s;
                press       <= ~key_s;
                release_evt <= key_s;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
    import fifo_demo_pkg::*;
(
    input  logic        sysc,
    input  logic        rst,
    fifo_port_if.mem    port
);

    // storage
    byte_t mem [FIFO_DEPTH];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    // occupancy, one bit wider than the pointers
    logic [FIFO_AW:0]   count;
    logic               do_wr;
    logic               do_rd;

    // flags straight from occupancy
    assign port.full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign port.empty = (count == '0);

    // requests past the flags are dropped
    assign do_wr = port.wr_en & ~port.full;
    assign do_rd = port.rd_en & ~port.empty;

    always_ff @(posedge sysc or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // array write
    always_ff @(posedge sysc) begin
        if (do_wr) begin
            mem[wr_ptr] <= port.din;
        end
    end

    // registered read port, one cycle behind rd_en
    always_ff @(posedge sysc) begin
        if (do_rd) begin
            port.dout <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_writer
    import fifo_demo_pkg::*;
(
    input  logic        sysc,
    input  logic        rst,
    input  logic        start,
    output logic        done,
    fifo_port_if.writer port
);

    // running byte value, wraps at 256 and survives across frames
    byte_t               value;
    // bytes still to go in this frame
    logic [FRAME_CW-1:0] left;
    logic                busy;

    assign busy = (left != '0);

    // push whenever there is room
    assign port.wr_en = busy & ~port.full;
    assign port.din   = value;

    always_ff @(posedge sysc or posedge rst) begin
        if (rst) begin
            value <= '0;
            left  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                // starts while busy are ignored
                if (start) begin
                    left <= FRAME_CW'(FRAME_LEN);
                end
            end else if (port.wr_en) begin
                value <= value + 1'b1;
                left  <= left - 1'b1;
                // last byte accepted, done shows next cycle
                done  <= (left == FRAME_CW'(1));
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_reader
    import fifo_demo_pkg::*;
(
    input  logic        sysc,
    input  logic        rst,
    input  logic        start,
    output logic        done,
    output frame_t      frame,
    fifo_port_if.reader port
);

    logic                active;
    // reads requested so far
    logic [FRAME_CW-1:0] issued;
    // bytes taken from dout so far
    logic [FRAME_CW-1:0] captured;
    // a read went out last cycle, dout holds its byte
    logic                rd_q;
    frame_t              work;
    frame_t              shifted;

    // stop requesting after a full frame
    assign port.rd_en = active & (issued != FRAME_CW'(FRAME_LEN)) & ~port.empty;

    // new byte enters at the bottom, first byte ends up on top
    assign shifted = {work[$bits(frame_t)-$bits(byte_t)-1:0], port.dout};

    always_ff @(posedge sysc or posedge rst) begin
        if (rst) begin
            active   <= 1'b0;
            issued   <= '0;
            captured <= '0;
            rd_q     <= 1'b0;
            done     <= 1'b0;
            frame    <= '0;
        end else begin
            done <= 1'b0;
            rd_q <= port.rd_en;
            if (!active) begin
                if (start) begin
                    active   <= 1'b1;
                    issued   <= '0;
                    captured <= '0;
                end
            end else begin
                if (port.rd_en) begin
                    issued <= issued + 1'b1;
                end
                if (rd_q) begin
                    captured <= captured + 1'b1;
                    // twelfth byte in, publish the whole frame
                    if (captured == FRAME_CW'(FRAME_LEN - 1)) begin
                        frame  <= shifted;
                        done   <= 1'b1;
                        active <= 1'b0;
                    end
                end
            end
        end
    end

    // working shift register
    always_ff @(posedge sysc) begin
        if (rd_q) begin
            work <= shifted;
        end
    end

endmodule

`default_nettype wire

// ==== source/read_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_sequencer
    import fifo_demo_pkg::*;
(
    input  logic sysc,
    input  logic rst,
    input  logic release_evt,
    input  logic write_done,
    input  logic read_done,
    output logic read_start
);

    typedef enum logic [2:0] {
        st_idle,
        st_wait,
        st_read,
        st_last,
        st_settle0,
        st_settle1
    } state_t;

    state_t           state;
    // frames written but not yet read back
    logic [FIFO_AW:0] pending;
    logic             go;

    // only a release in wait with something queued starts a read
    assign go = (state == st_wait) && release_evt && (pending != '0);

    always_ff @(posedge sysc or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            pending    <= '0;
            read_start <= 1'b0;
        end else begin
            read_start <= go;
            case ({write_done, read_start})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: pending <= pending;
            endcase
            case (state)
                st_idle: state <= st_wait;
                st_wait: begin
                    if (go) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    if (read_done) begin
                        state <= st_last;
                    end
                end
                // settle before accepting the next release
                st_last:    state <= st_settle0;
                st_settle0: state <= st_settle1;
                st_settle1: state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/led_pager.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_pager
    import fifo_demo_pkg::*;
(
    input  logic   sysc,
    input  logic   rst,
    input  logic   next_page,
    input  frame_t frame,
    output lec_t   lec,
    output led_t   led
);

    page_t page;

    // step through the pages, wrap after the last
    always_ff @(posedge sysc or posedge rst) begin
        if (rst) begin
            page <= '0;
        end else if (next_page) begin
            if (page == page_t'(PAGE_COUNT - 1)) begin
                page <= '0;
            end else begin
                page <= page + 1'b1;
            end
        end
    end

    // one-hot page marker
    assign lec = lec_t'(1) << page;

    // page n shows bytes 4n..4n+3, lowest byte on led[31:24]
    always_comb begin : page_sel
        int base;
        base = $bits(frame_t) - 1 - int'(page) * BYTES_PER_PAGE * $bits(byte_t);
        led  = frame[base -: $bits(led_t)];
    end

endmodule

`default_nettype wire

// ==== source/fifo_demo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_demo_top
    import fifo_demo_pkg::*;
(
    input  logic       sysc,
    input  logic       rst,
    input  logic [1:0] key,
    output lec_t       lec,
    output led_t       led
);

    // key 0 events
    logic   load_press;
    logic   load_release;
    // key 1 press, page step
    logic   page_press;

    logic   write_done;
    logic   read_start;
    logic   read_done;
    frame_t frame;

    fifo_port_if fifo_port ();

    // key 0, press writes a frame and release reads it back
    key_debounce i_key0 (
        .sysc        (sysc),
        .rst         (rst),
        .key_n       (key[0]),
        .press       (load_press),
        .release_evt (load_release)
    );

    // key 1, only the press matters
    key_debounce i_key1 (
        .sysc        (sysc),
        .rst         (rst),
        .key_n       (key[1]),
        .press       (page_press),
        .release_evt ()
    );

    sync_fifo i_fifo (
        .sysc (sysc),
        .rst  (rst),
        .port (fifo_port)
    );

    frame_writer i_writer (
        .sysc  (sysc),
        .rst   (rst),
        .start (load_press),
        .done  (write_done),
        .port  (fifo_port)
    );

    frame_reader i_reader (
        .sysc  (sysc),
        .rst   (rst),
        .start (read_start),
        .done  (read_done),
        .frame (frame),
        .port  (fifo_port)
    );

    read_sequencer i_seq (
        .sysc        (sysc),
        .rst         (rst),
        .release_evt (load_release),
        .write_done  (write_done),
        .read_done   (read_done),
        .read_start  (read_start)
    );

    led_pager i_pager (
        .sysc      (sysc),
        .rst       (rst),
        .next_page (page_press),
        .frame     (frame),
        .lec       (lec),
        .led       (led)
    );

endmodule

`default_nettype wire

// ==== sim/fifo_demo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_demo_tb
    import fifo_demo_pkg::*;
();

    // hold time of a key level, in cycles
    localparam int HOLD = 3 * DEBOUNCE_CYCLES;
    // cycles of unchanged leds that count as settled
    localparam int SETTLE = 2 * DEBOUNCE_CYCLES;
    localparam int SETTLE_LIMIT = 40 * DEBOUNCE_CYCLES;

    logic       sysc;
    logic       rst;
    logic [1:0] key;
    lec_t       lec;
    led_t       led;

    integer seed;
    integer fd;
    int     op_total;
    string  line;

    fifo_demo_top i_dut (
        .sysc (sysc),
        .rst  (rst),
        .key  (key),
        .lec  (lec),
        .led  (led)
    );

    initial begin
        sysc = 1'b0;
        forever #5 sysc = ~sysc;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_lec(input lec_t exp);
        if (lec !== exp) begin
            $display("Error: time %0t lec expected %h got %h", $time, exp, lec);
            $display("TESTBENCH FAILED");
            $fatal(1, "lec mismatch");
        end
    endtask

    task automatic check_led(input led_t exp);
        if (led !== exp) begin
            $display("Error: time %0t led expected %h got %h", $time, exp, led);
            $display("TESTBENCH FAILED");
            $fatal(1, "led mismatch");
        end
    endtask

    // key low for HOLD cycles, then released and idle as long
    task automatic press_key(input int k);
        @(posedge sysc);
        key[k] <= 1'b0;
        repeat (HOLD) @(posedge sysc);
        key[k] <= 1'b1;
        repeat (HOLD) @(posedge sysc);
    endtask

    // low pulses well under the debounce time
    task automatic bounce_key(input int k);
        int pulses;
        int width;
        int gap;
        pulses = 2 + ($unsigned($random(seed)) % 4);
        repeat (pulses) begin
            width = 1 + ($unsigned($random(seed)) % (DEBOUNCE_CYCLES / 2));
            gap = 1 + ($unsigned($random(seed)) % 8);
            @(posedge sysc);
            key[k] <= 1'b0;
            repeat (width) @(posedge sysc);
            key[k] <= 1'b1;
            repeat (gap) @(posedge sysc);
        end
        repeat (HOLD) @(posedge sysc);
    endtask

    // sample on falling edges until leds hold still
    task automatic wait_settled;
        lec_t last_lec;
        led_t last_led;
        int   stable;
        int   waited;
        stable = 0;
        waited = 0;
        @(negedge sysc);
        last_lec = lec;
        last_led = led;
        while (stable < SETTLE) begin
            @(negedge sysc);
            waited++;
            if (lec === last_lec && led === last_led) begin
                stable++;
            end else begin
                stable = 0;
                last_lec = lec;
                last_led = led;
            end
            if (waited > SETTLE_LIMIT) begin
                stop_run("leds never settled");
            end
        end
    endtask

    task automatic open_stim;
        fd = $fopen("sim/fifo_demo_stim.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open sim/fifo_demo_stim.txt");
        end
    endtask

    // one stimulus line, run it or just count it
    task automatic do_line(input string text, input bit run);
        string op;
        int    num;
        lec_t  exp_lec;
        led_t  exp_led;
        int    n;
        n = $sscanf(text, "%s", op);
        if (n < 1 || text[0] == "#") begin
            return;
        end
        if (op == "check") begin
            n = $sscanf(text, "%s %h %h", op, exp_lec, exp_led);
        end else begin
            n = $sscanf(text, "%s %d", op, num);
        end
        if ((op == "check" && n != 3) || (op != "check" && n != 2)) begin
            stop_run({"malformed stimulus line: ", text});
        end
        if (!run) begin
            op_total += (op == "repeat") ? num : 1;
        end else if (op == "press") begin
            press_key(num);
        end else if (op == "bounce") begin
            bounce_key(num);
        end else if (op == "repeat") begin
            repeat (num) press_key(0);
        end else if (op == "check") begin
            wait_settled();
            check_lec(exp_lec);
            check_led(exp_led);
        end else begin
            stop_run({"unknown stimulus operation: ", op});
        end
    endtask

    // limit grows with the number of operations
    initial begin : watchdog
        wait (op_total > 0);
        #(op_total * 8 * DEBOUNCE_CYCLES * 10 + 5000);
        stop_run("timeout, run took too long");
    end

    initial begin : stimulus
        rst = 1'b1;
        key = 2'b11;
        seed = 11;
        op_total = 0;
        // first pass only sizes the watchdog
        open_stim();
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                do_line(line, 1'b0);
            end
        end
        $fclose(fd);
        repeat (5) @(posedge sysc);
        rst <= 1'b0;
        open_stim();
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                do_line(line, 1'b1);
            end
        end
        $fclose(fd);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/fifo_demo_stim.txt ====
# op     args     press/bounce take a key number, repeat a count of key 0 presses
# check  lec led  expected page leds and data leds, both hex
check  1 00000000
press  0
check  1 00010203
press  1
check  2 04050607
press  1
check  4 08090a0b
press  1
check  1 00010203
press  0
check  1 0c0d0e0f
press  1
check  2 10111213
press  0
check  2 1c1d1e1f
bounce 1
check  2 1c1d1e1f
bounce 0
check  2 1c1d1e1f
repeat 18
check  2 f4f5f6f7
press  0
check  2 00010203
press  1
check  4 04050607
press  1
check  1 fcfdfeff

// ==== project.f ====
source/fifo_demo_pkg.sv
source/fifo_port_if.sv
source/key_debounce.sv
source/sync_fifo.sv
source/frame_writer.sv
source/frame_reader.sv
source/read_sequencer.sv
source/led_pager.sv
source/fifo_demo_top.sv
sim/fifo_demo_tb.sv

// ==== Bender.yml ====
package:
  name: fifo_demo

sources:
  - files:
      - source/fifo_demo_pkg.sv
      - source/fifo_port_if.sv
      - source/key_debounce.sv
      - source/sync_fifo.sv
      - source/frame_writer.sv
      - source/frame_reader.sv
      - source/read_sequencer.sv
      - source/led_pager.sv
      - source/fifo_demo_top.sv
  - target: test
    files:
      - sim/fifo_demo_tb.sv
